// File: src/island_pkg.sv
package island_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // --------------------
  // Address map
  // --------------------
  localparam int unsigned BankNumWords = 256;
  localparam logic [AddrWidth-1:0] BankBytes = AddrWidth'(BankNumWords * 4);

  localparam logic [AddrWidth-1:0] Bank0Base   = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] Bank1Base   = 32'h0000_0400;
  localparam logic [AddrWidth-1:0] PeriphBase  = 32'h0000_2000;
  localparam logic [AddrWidth-1:0] SocCtrlSize = 32'h0000_0010;

  // Boot address points into the peripheral region out of reset
  localparam logic [AddrWidth-1:0] BootAddrDefault = PeriphBase + 32'h0000_0080;

  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADC_AB1E;

  // SoC control register offsets
  localparam logic [AddrWidth-1:0] RegBootAddrOff = 32'h0;
  localparam logic [AddrWidth-1:0] RegFetchEnOff  = 32'h4;
  localparam logic [AddrWidth-1:0] RegBootModeOff = 32'h8;

  // --------------------
  // Enums
  // --------------------
  typedef enum logic [1:0] {
    BootPassive   = 2'd0,
    BootJtag      = 2'd1,
    BootPreloaded = 2'd2
  } bootmode_e;

  typedef enum logic [1:0] {
    TgtBank0   = 2'd0,
    TgtBank1   = 2'd1,
    TgtSocCtrl = 2'd2,
    TgtError   = 2'd3
  } target_e;

  typedef enum logic [1:0] {
    ArbIdle = 2'd0,
    ArbWait = 2'd1,
    ArbRsp  = 2'd2
  } arb_state_e;

endpackage

// File: src/island_bus_if.sv
`timescale 1ns/1ps

interface island_bus_if;
  import island_pkg::*;

  // Request side
  logic                 req_valid;
  logic                 req_ready;
  logic [AddrWidth-1:0] addr;
  logic                 we;
  logic [StrbWidth-1:0] be;
  logic [DataWidth-1:0] wdata;

  // Response side, one cycle wide and without ready
  logic                 rsp_valid;
  logic [DataWidth-1:0] rdata;
  logic                 err;

  modport mgr (
    output req_valid, addr, we, be, wdata,
    input  req_ready, rsp_valid, rdata, err
  );

  modport sbr (
    input  req_valid, addr, we, be, wdata,
    output req_ready, rsp_valid, rdata, err
  );

endinterface

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Host manager
  input  logic                             host_req_valid_i,
  output logic                             host_req_ready_o,
  input  logic [island_pkg::AddrWidth-1:0] host_addr_i,
  input  logic                             host_we_i,
  input  logic [island_pkg::StrbWidth-1:0] host_be_i,
  input  logic [island_pkg::DataWidth-1:0] host_wdata_i,
  output logic                             host_rsp_valid_o,
  input  logic                             host_rsp_ready_i,
  output logic [island_pkg::DataWidth-1:0] host_rdata_o,
  output logic                             host_err_o,
  // Debug manager
  input  logic                             dbg_req_valid_i,
  output logic                             dbg_req_ready_o,
  input  logic [island_pkg::AddrWidth-1:0] dbg_addr_i,
  input  logic                             dbg_we_i,
  input  logic [island_pkg::StrbWidth-1:0] dbg_be_i,
  input  logic [island_pkg::DataWidth-1:0] dbg_wdata_i,
  output logic                             dbg_rsp_valid_o,
  input  logic                             dbg_rsp_ready_i,
  output logic [island_pkg::DataWidth-1:0] dbg_rdata_o,
  output logic                             dbg_err_o,
  // Shared bus
  island_bus_if.mgr                        bus
);
  import island_pkg::*;

  arb_state_e           state_q, state_d;
  logic                 gnt_dbg_q;
  logic                 idle;
  logic                 gnt_host, gnt_dbg;
  logic                 bus_hs;
  logic                 rsp_ready_sel;
  logic [DataWidth-1:0] rdata_q;
  logic                 err_q;

  assign idle = (state_q == ArbIdle);

  // Round robin, the side not granted last wins a tie
  assign gnt_host = host_req_valid_i & (~dbg_req_valid_i | gnt_dbg_q);
  assign gnt_dbg  = dbg_req_valid_i & (~host_req_valid_i | ~gnt_dbg_q);

  assign host_req_ready_o = idle & bus.req_ready & ~gnt_dbg;
  assign dbg_req_ready_o  = idle & bus.req_ready & ~gnt_host;

  assign bus.req_valid = idle & (gnt_host | gnt_dbg);
  assign bus.addr      = gnt_dbg ? dbg_addr_i : host_addr_i;
  assign bus.we        = gnt_dbg ? dbg_we_i : host_we_i;
  assign bus.be        = gnt_dbg ? dbg_be_i : host_be_i;
  assign bus.wdata     = gnt_dbg ? dbg_wdata_i : host_wdata_i;

  assign bus_hs        = bus.req_valid & bus.req_ready;
  assign rsp_ready_sel = gnt_dbg_q ? dbg_rsp_ready_i : host_rsp_ready_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ArbIdle: if (bus_hs) state_d = ArbWait;
      ArbWait: if (bus.rsp_valid) state_d = ArbRsp;
      ArbRsp:  if (rsp_ready_sel) state_d = ArbIdle;
      default: state_d = ArbIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ArbIdle;
      gnt_dbg_q <= 1'b1;
    end else begin
      state_q <= state_d;
      if (bus_hs) begin
        gnt_dbg_q <= gnt_dbg;
      end
    end
  end

  // Response is only on the bus for one cycle
  always_ff @(posedge clk_i) begin
    if (state_q == ArbWait && bus.rsp_valid) begin
      rdata_q <= bus.rdata;
      err_q   <= bus.err;
    end
  end

  assign host_rsp_valid_o = (state_q == ArbRsp) & ~gnt_dbg_q;
  assign dbg_rsp_valid_o  = (state_q == ArbRsp) & gnt_dbg_q;
  assign host_rdata_o     = rdata_q;
  assign dbg_rdata_o      = rdata_q;
  assign host_err_o       = err_q;
  assign dbg_err_o        = err_q;

  // --------------------
  // Assertions
  // --------------------
  // Both managers are held off once a grant has gone out
  a_ready_low_after_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_hs |=> !host_req_ready_o && !dbg_req_ready_o);

  a_rsp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == ArbRsp && !rsp_ready_sel)
      |=> state_q == ArbRsp && $stable(rdata_q) && $stable(err_q));

  // Router never answers without an outstanding grant
  a_no_rsp_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    idle |-> !bus.rsp_valid);

endmodule

// File: src/addr_router.sv
`timescale 1ns/1ps

module addr_router (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  island_bus_if.sbr                        bus,
  // Target strobes
  output logic                             bank0_req_o,
  output logic                             bank1_req_o,
  output logic                             soc_req_o,
  // Common target request fields
  output logic [island_pkg::AddrWidth-1:0] tgt_addr_o,
  output logic                             tgt_we_o,
  output logic [island_pkg::StrbWidth-1:0] tgt_be_o,
  output logic [island_pkg::DataWidth-1:0] tgt_wdata_o,
  // Target responses
  input  logic [island_pkg::DataWidth-1:0] bank0_rdata_i,
  input  logic [island_pkg::DataWidth-1:0] bank1_rdata_i,
  input  logic [island_pkg::DataWidth-1:0] soc_rdata_i,
  input  logic                             soc_err_i
);
  import island_pkg::*;

  target_e              tgt_d, tgt_q;
  logic                 pending_q;
  logic                 we_q;
  logic                 hs;
  logic [AddrWidth-1:0] off_bank0, off_bank1, off_soc;

  // Offsets wrap below each base, so one compare covers both bounds
  assign off_bank0 = bus.addr - Bank0Base;
  assign off_bank1 = bus.addr - Bank1Base;
  assign off_soc   = bus.addr - PeriphBase;

  always_comb begin
    if (off_bank0 < BankBytes) begin
      tgt_d      = TgtBank0;
      tgt_addr_o = off_bank0;
    end else if (off_bank1 < BankBytes) begin
      tgt_d      = TgtBank1;
      tgt_addr_o = off_bank1;
    end else if (off_soc < SocCtrlSize) begin
      tgt_d      = TgtSocCtrl;
      tgt_addr_o = off_soc;
    end else begin
      tgt_d      = TgtError;
      tgt_addr_o = bus.addr;
    end
  end

  assign bus.req_ready = ~pending_q;
  assign hs            = bus.req_valid & bus.req_ready;

  assign bank0_req_o = hs & (tgt_d == TgtBank0);
  assign bank1_req_o = hs & (tgt_d == TgtBank1);
  assign soc_req_o   = hs & (tgt_d == TgtSocCtrl);
  assign tgt_we_o    = bus.we;
  assign tgt_be_o    = bus.be;
  assign tgt_wdata_o = bus.wdata;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      tgt_q     <= TgtError;
      we_q      <= 1'b0;
    end else begin
      pending_q <= hs;
      if (hs) begin
        tgt_q <= tgt_d;
        we_q  <= bus.we;
      end
    end
  end

  // Response mux, valid one edge after the handshake
  assign bus.rsp_valid = pending_q;

  always_comb begin
    bus.rdata = '0;
    bus.err   = 1'b0;
    unique case (tgt_q)
      TgtBank0: bus.rdata = bank0_rdata_i;
      TgtBank1: bus.rdata = bank1_rdata_i;
      TgtSocCtrl: begin
        bus.rdata = soc_rdata_i;
        bus.err   = soc_err_i;
      end
      default: begin
        bus.rdata = we_q ? '0 : ErrRspData;
        bus.err   = 1'b1;
      end
    endcase
  end

  // Manager holds off while a response is pending
  a_no_req_while_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pending_q |-> !bus.req_valid);

endmodule

// File: src/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned NumWords = island_pkg::BankNumWords
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [island_pkg::StrbWidth-1:0] be_i,
  input  logic [island_pkg::AddrWidth-1:0] addr_i,
  input  logic [island_pkg::DataWidth-1:0] wdata_i,
  output logic [island_pkg::DataWidth-1:0] rdata_o
);
  import island_pkg::*;

  logic [DataWidth-1:0]        mem [NumWords];
  logic [$clog2(NumWords)-1:0] word_idx;

  // Byte address to word index
  assign word_idx = addr_i[$clog2(NumWords)+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (be_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Registered read, writes answer with zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (req_i) begin
      rdata_o <= we_i ? '0 : mem[word_idx];
    end
  end

endmodule

// File: src/soc_ctrl_regs.sv
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             req_i,
  input  logic                             we_i,
  input  logic [island_pkg::AddrWidth-1:0] addr_i,
  input  logic [island_pkg::DataWidth-1:0] wdata_i,
  input  island_pkg::bootmode_e            bootmode_i,
  input  logic                             fetch_enable_i,
  output logic [island_pkg::DataWidth-1:0] rdata_o,
  output logic                             err_o,
  output logic                             fetch_enable_o,
  output logic [island_pkg::AddrWidth-1:0] boot_addr_o
);
  import island_pkg::*;

  logic                 first_cycle_q;
  logic [AddrWidth-1:0] boot_addr_q;
  logic                 fetchen_q;
  bootmode_e            bootmode_q;
  logic [DataWidth-1:0] rdata_d;
  logic                 err_d;
  logic                 wr;

  assign wr = req_i & we_i;

  // --------------------
  // Read decode
  // --------------------
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (addr_i)
      RegBootAddrOff: rdata_d = boot_addr_q;
      RegFetchEnOff:  rdata_d = DataWidth'(fetchen_q);
      RegBootModeOff: rdata_d = DataWidth'(bootmode_q);
      default:        err_d   = 1'b1;
    endcase
  end

  // --------------------
  // Registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_cycle_q <= 1'b1;
      boot_addr_q   <= BootAddrDefault;
      fetchen_q     <= 1'b0;
      bootmode_q    <= BootPassive;
    end else begin
      first_cycle_q <= 1'b0;
      if (wr && addr_i == RegBootAddrOff) begin
        boot_addr_q <= wdata_i;
      end
      // Hardware capture takes the first edge after reset
      if (first_cycle_q) begin
        bootmode_q <= bootmode_i;
        fetchen_q  <= (bootmode_i == BootJtag);
      end else if (wr) begin
        if (addr_i == RegFetchEnOff) fetchen_q <= wdata_i[0];
        if (addr_i == RegBootModeOff) bootmode_q <= bootmode_e'(wdata_i[1:0]);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
      err_o   <= 1'b0;
    end else if (req_i) begin
      rdata_o <= we_i ? '0 : rdata_d;
      err_o   <= err_d;
    end
  end

  assign fetch_enable_o = fetchen_q | fetch_enable_i;
  assign boot_addr_o    = boot_addr_q;

endmodule

// File: src/island_top.sv
`timescale 1ns/1ps

module island_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  island_pkg::bootmode_e            bootmode_i,
  input  logic                             fetch_enable_i,
  // Host manager
  input  logic                             host_req_valid_i,
  output logic                             host_req_ready_o,
  input  logic [island_pkg::AddrWidth-1:0] host_addr_i,
  input  logic                             host_we_i,
  input  logic [island_pkg::StrbWidth-1:0] host_be_i,
  input  logic [island_pkg::DataWidth-1:0] host_wdata_i,
  output logic                             host_rsp_valid_o,
  input  logic                             host_rsp_ready_i,
  output logic [island_pkg::DataWidth-1:0] host_rdata_o,
  output logic                             host_err_o,
  // Debug manager
  input  logic                             dbg_req_valid_i,
  output logic                             dbg_req_ready_o,
  input  logic [island_pkg::AddrWidth-1:0] dbg_addr_i,
  input  logic                             dbg_we_i,
  input  logic [island_pkg::StrbWidth-1:0] dbg_be_i,
  input  logic [island_pkg::DataWidth-1:0] dbg_wdata_i,
  output logic                             dbg_rsp_valid_o,
  input  logic                             dbg_rsp_ready_i,
  output logic [island_pkg::DataWidth-1:0] dbg_rdata_o,
  output logic                             dbg_err_o,
  // Control outputs
  output logic                             fetch_enable_o,
  output logic [island_pkg::AddrWidth-1:0] boot_addr_o
);
  import island_pkg::*;

  logic                 bank0_req, bank1_req, soc_req;
  logic [AddrWidth-1:0] tgt_addr;
  logic                 tgt_we;
  logic [StrbWidth-1:0] tgt_be;
  logic [DataWidth-1:0] tgt_wdata;
  logic [DataWidth-1:0] bank0_rdata, bank1_rdata, soc_rdata;
  logic                 soc_err;

  island_bus_if shared_bus ();

  // --------------------
  // Interconnect
  // --------------------
  bus_arbiter u_arbiter (
    .clk_i,
    .rst_ni,
    .host_req_valid_i,
    .host_req_ready_o,
    .host_addr_i,
    .host_we_i,
    .host_be_i,
    .host_wdata_i,
    .host_rsp_valid_o,
    .host_rsp_ready_i,
    .host_rdata_o,
    .host_err_o,
    .dbg_req_valid_i,
    .dbg_req_ready_o,
    .dbg_addr_i,
    .dbg_we_i,
    .dbg_be_i,
    .dbg_wdata_i,
    .dbg_rsp_valid_o,
    .dbg_rsp_ready_i,
    .dbg_rdata_o,
    .dbg_err_o,
    .bus (shared_bus.mgr)
  );

  addr_router u_router (
    .clk_i,
    .rst_ni,
    .bus           (shared_bus.sbr),
    .bank0_req_o   (bank0_req),
    .bank1_req_o   (bank1_req),
    .soc_req_o     (soc_req),
    .tgt_addr_o    (tgt_addr),
    .tgt_we_o      (tgt_we),
    .tgt_be_o      (tgt_be),
    .tgt_wdata_o   (tgt_wdata),
    .bank0_rdata_i (bank0_rdata),
    .bank1_rdata_i (bank1_rdata),
    .soc_rdata_i   (soc_rdata),
    .soc_err_i     (soc_err)
  );

  // --------------------
  // Targets
  // --------------------
  sram_bank #(.NumWords(BankNumWords)) u_bank0 (
    .clk_i,
    .rst_ni,
    .req_i   (bank0_req),
    .we_i    (tgt_we),
    .be_i    (tgt_be),
    .addr_i  (tgt_addr),
    .wdata_i (tgt_wdata),
    .rdata_o (bank0_rdata)
  );

  sram_bank #(.NumWords(BankNumWords)) u_bank1 (
    .clk_i,
    .rst_ni,
    .req_i   (bank1_req),
    .we_i    (tgt_we),
    .be_i    (tgt_be),
    .addr_i  (tgt_addr),
    .wdata_i (tgt_wdata),
    .rdata_o (bank1_rdata)
  );

  soc_ctrl_regs u_soc_ctrl (
    .clk_i,
    .rst_ni,
    .req_i          (soc_req),
    .we_i           (tgt_we),
    .addr_i         (tgt_addr),
    .wdata_i        (tgt_wdata),
    .bootmode_i,
    .fetch_enable_i,
    .rdata_o        (soc_rdata),
    .err_o          (soc_err),
    .fetch_enable_o,
    .boot_addr_o
  );

endmodule

// File: dv/island_checker.sv
`timescale 1ns/1ps

module island_checker (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  island_pkg::bootmode_e                 bootmode_i,
  input  logic                                  fetch_enable_i,
  // Index 0 is the host manager, index 1 the debug manager
  input  logic [1:0]                            req_valid_i,
  input  logic [1:0]                            req_ready_i,
  input  logic [1:0][island_pkg::AddrWidth-1:0] addr_i,
  input  logic [1:0]                            we_i,
  input  logic [1:0][island_pkg::StrbWidth-1:0] be_i,
  input  logic [1:0][island_pkg::DataWidth-1:0] wdata_i,
  input  logic [1:0]                            rsp_valid_i,
  input  logic [1:0]                            rsp_ready_i,
  input  logic [1:0][island_pkg::DataWidth-1:0] rdata_i,
  input  logic [1:0]                            err_i,
  input  logic                                  dut_fetch_en_i,
  input  logic [island_pkg::AddrWidth-1:0]      dut_boot_addr_i,
  output int                                    err_count_o,
  output int                                    txn_count_o
);
  import island_pkg::*;

  // Memory and register model
  logic [DataWidth-1:0] bank_m [2][BankNumWords];
  logic [AddrWidth-1:0] boot_addr_m;
  logic                 fetchen_m;
  logic [1:0]           bootmode_m;

  // Outstanding response per manager
  logic [1:0]           pend;
  logic [1:0]           seen;
  int                   hs_cyc [2];
  logic [DataWidth-1:0] exp_rdata [2];
  logic [1:0]           exp_err;

  logic [1:0]           prev_valid, prev_ready, prev_err;
  logic [DataWidth-1:0] prev_rdata [2];
  logic                 last_dbg;
  logic                 busy;
  int                   cyc;
  int                   errors = 0;
  int                   txns = 0;

  assign err_count_o = errors;
  assign txn_count_o = txns;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] t=%0t %s", $time, msg);
  endtask

  // --------------------
  // Model update
  // --------------------
  task automatic predict(input int m);
    logic [AddrWidth-1:0] a;
    logic [AddrWidth-1:0] off;
    int unsigned          bank;
    int unsigned          word;
    a = addr_i[m];
    exp_rdata[m] = '0;
    exp_err[m]   = 1'b0;
    if (a < Bank1Base + BankNumWords * 4) begin
      bank = (a >= Bank1Base) ? 1 : 0;
      word = (a - (bank == 1 ? Bank1Base : Bank0Base)) / 4;
      if (we_i[m]) begin
        for (int b = 0; b < StrbWidth; b++) begin
          if (be_i[m][b]) begin
            bank_m[bank][word][8*b +: 8] = wdata_i[m][8*b +: 8];
          end
        end
      end else begin
        exp_rdata[m] = bank_m[bank][word];
      end
    end else if (a >= PeriphBase && a < PeriphBase + SocCtrlSize) begin
      off = a - PeriphBase;
      if (off == RegBootAddrOff) begin
        if (we_i[m]) boot_addr_m = wdata_i[m];
        else exp_rdata[m] = boot_addr_m;
      end else if (off == RegFetchEnOff) begin
        if (we_i[m]) fetchen_m = wdata_i[m][0];
        else exp_rdata[m] = {31'b0, fetchen_m};
      end else if (off == RegBootModeOff) begin
        if (we_i[m]) bootmode_m = wdata_i[m][1:0];
        else exp_rdata[m] = {30'b0, bootmode_m};
      end else begin
        exp_err[m] = 1'b1;
      end
    end else begin
      // Unmapped, writes are dropped
      exp_err[m] = 1'b1;
      if (!we_i[m]) exp_rdata[m] = 32'hBADC_AB1E;
    end
  endtask

  // --------------------
  // Response side
  // --------------------
  task automatic check_response(input int m, input logic was_busy);
    string who;
    who = (m == 1) ? "dbg" : "host";
    if (was_busy && req_ready_i[m]) begin
      report_error($sformatf("%s_req_ready_o high while a response is pending", who));
    end
    if (prev_valid[m] && !prev_ready[m] && (!rsp_valid_i[m] ||
        rdata_i[m] !== prev_rdata[m] || err_i[m] !== prev_err[m])) begin
      report_error($sformatf("%s response dropped or changed before its handshake", who));
    end
    if (rsp_valid_i[m] && !pend[m]) begin
      report_error($sformatf("%s_rsp_valid_o high with no request outstanding", who));
    end else if (pend[m] && !seen[m]) begin
      if (rsp_valid_i[m]) begin
        seen[m] = 1'b1;
        if (cyc - hs_cyc[m] != 2) begin
          report_error($sformatf("%s response came %0d edges after the handshake, not 2",
                                 who, cyc - hs_cyc[m]));
        end
      end else if (cyc - hs_cyc[m] > 2) begin
        seen[m] = 1'b1;
        report_error($sformatf("%s response missing two edges after the handshake", who));
      end
    end
    if (pend[m] && rsp_valid_i[m] && rsp_ready_i[m]) begin
      if (rdata_i[m] !== exp_rdata[m]) begin
        report_mismatch({who, "_rdata_o"}, rdata_i[m], exp_rdata[m]);
      end
      if (err_i[m] !== exp_err[m]) begin
        report_mismatch({who, "_err_o"}, 32'(err_i[m]), 32'(exp_err[m]));
      end
      pend[m] = 1'b0;
      txns++;
    end
    prev_valid[m] = rsp_valid_i[m];
    prev_ready[m] = rsp_ready_i[m];
    prev_rdata[m] = rdata_i[m];
    prev_err[m]   = err_i[m];
  endtask

  // --------------------
  // Request side
  // --------------------
  task automatic check_requests(input logic was_busy);
    logic [1:0] hs;
    logic       winner;
    hs = req_valid_i & req_ready_i;
    if (!was_busy && req_valid_i != 2'b00) begin
      // On a tie the side not granted last wins
      winner = (req_valid_i == 2'b11) ? ~last_dbg : req_valid_i[1];
      if (hs != (2'b01 << winner)) begin
        report_error($sformatf("arbitration expected the %s request to transfer, saw %b",
                               winner ? "dbg" : "host", hs));
      end
    end
    for (int m = 0; m < 2; m++) begin
      if (hs[m]) begin
        last_dbg  = (m == 1);
        predict(m);
        pend[m]   = 1'b1;
        seen[m]   = 1'b0;
        hs_cyc[m] = cyc;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      cyc         = 0;
      pend        = '0;
      seen        = '0;
      prev_valid  = '0;
      prev_ready  = '0;
      last_dbg    = 1'b1;
      boot_addr_m = BootAddrDefault;
      // Captured on the first edge after reset
      fetchen_m   = (bootmode_i == BootJtag);
      bootmode_m  = bootmode_i;
    end else begin
      cyc++;
      busy = |pend;
      if (cyc == 2 && (rsp_valid_i != 2'b00 || req_ready_i != 2'b11)) begin
        report_error("after reset both rsp_valid_o are not low or both req_ready_o not high");
      end
      if (cyc >= 2) begin
        if (dut_fetch_en_i !== (fetchen_m | fetch_enable_i)) begin
          report_mismatch("fetch_enable_o", 32'(dut_fetch_en_i),
                          32'(fetchen_m | fetch_enable_i));
        end
        if (dut_boot_addr_i !== boot_addr_m) begin
          report_mismatch("boot_addr_o", dut_boot_addr_i, boot_addr_m);
        end
      end
      for (int m = 0; m < 2; m++) begin
        check_response(m, busy);
      end
      check_requests(busy);
    end
  end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import island_pkg::*;

  localparam int unsigned Seed = 32'h5769_a121;
  localparam int ClkPeriod     = 10;
  localparam int ResetCycles   = 16;
  localparam int RandomTxns    = 200;
  localparam int UnmappedIters = 32;
  localparam int TotalTxns     = 2 * BankNumWords + 6 * RandomTxns + 3 * UnmappedIters + 16;
  localparam int WatchdogCycles = TotalTxns * 40 + ResetCycles;

  logic                      clk;
  logic                      rst_n;
  bootmode_e                 bootmode;
  logic                      fetch_enable;
  // Index 0 is the host manager, index 1 the debug manager
  logic [1:0]                req_valid, req_ready, we, rsp_valid, rsp_ready, err;
  logic [1:0][AddrWidth-1:0] addr;
  logic [1:0][StrbWidth-1:0] be;
  logic [1:0][DataWidth-1:0] wdata, rdata;
  logic                      dut_fetch_en;
  logic [AddrWidth-1:0]      dut_boot_addr;

  int   check_errors, check_txns;
  int   issued = 0;
  int   tests_run = 0;
  int   txns_mark = 0;
  int   errors_mark = 0;
  logic bp_mode;

  island_top u_dut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .bootmode_i       (bootmode),
    .fetch_enable_i   (fetch_enable),
    .host_req_valid_i (req_valid[0]),
    .host_req_ready_o (req_ready[0]),
    .host_addr_i      (addr[0]),
    .host_we_i        (we[0]),
    .host_be_i        (be[0]),
    .host_wdata_i     (wdata[0]),
    .host_rsp_valid_o (rsp_valid[0]),
    .host_rsp_ready_i (rsp_ready[0]),
    .host_rdata_o     (rdata[0]),
    .host_err_o       (err[0]),
    .dbg_req_valid_i  (req_valid[1]),
    .dbg_req_ready_o  (req_ready[1]),
    .dbg_addr_i       (addr[1]),
    .dbg_we_i         (we[1]),
    .dbg_be_i         (be[1]),
    .dbg_wdata_i      (wdata[1]),
    .dbg_rsp_valid_o  (rsp_valid[1]),
    .dbg_rsp_ready_i  (rsp_ready[1]),
    .dbg_rdata_o      (rdata[1]),
    .dbg_err_o        (err[1]),
    .fetch_enable_o   (dut_fetch_en),
    .boot_addr_o      (dut_boot_addr)
  );

  island_checker u_checker (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .bootmode_i      (bootmode),
    .fetch_enable_i  (fetch_enable),
    .req_valid_i     (req_valid),
    .req_ready_i     (req_ready),
    .addr_i          (addr),
    .we_i            (we),
    .be_i            (be),
    .wdata_i         (wdata),
    .rsp_valid_i     (rsp_valid),
    .rsp_ready_i     (rsp_ready),
    .rdata_i         (rdata),
    .err_i           (err),
    .dut_fetch_en_i  (dut_fetch_en),
    .dut_boot_addr_i (dut_boot_addr),
    .err_count_o     (check_errors),
    .txn_count_o     (check_txns)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired after %0d cycles before the tests finished", WatchdogCycles);
    $display("STATUS: FAIL");
    $finish;
  end

  // --------------------
  // Stimulus
  // --------------------
  task automatic run_txn(input int m, input logic [AddrWidth-1:0] a, input logic w,
                         input logic [StrbWidth-1:0] b, input logic [DataWidth-1:0] d);
    logic done;
    @(negedge clk);
    rsp_ready[m] = 1'b0;
    req_valid[m] = 1'b1;
    addr[m]      = a;
    we[m]        = w;
    be[m]        = b;
    wdata[m]     = d;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = req_ready[m];
    end
    @(negedge clk);
    req_valid[m] = 1'b0;
    done = 1'b0;
    while (!done) begin
      rsp_ready[m] = bp_mode ? 1'($urandom_range(1)) : 1'b1;
      @(posedge clk);
      done = rsp_valid[m] & rsp_ready[m];
      if (!done) @(negedge clk);
    end
    issued++;
  endtask

  function automatic logic [AddrWidth-1:0] random_bank_addr();
    logic [AddrWidth-1:0] base;
    base = ($urandom_range(1) == 1) ? Bank1Base : Bank0Base;
    return base + 4 * $urandom_range(BankNumWords - 1);
  endfunction

  function automatic logic [AddrWidth-1:0] random_unmapped_addr();
    case ($urandom_range(2))
      0: return 32'h0000_0800 + 4 * $urandom_range(32'h5FF);
      1: return 32'h0000_2010 + 4 * $urandom_range(32'h3FF);
      default: return 32'h8000_0000 | ($urandom & 32'h7FFF_FFFC);
    endcase
  endfunction

  task automatic random_traffic(input int m, input int n);
    repeat (n) begin
      run_txn(m, random_bank_addr(), 1'($urandom_range(1)), 4'($urandom), $urandom);
    end
  endtask

  task automatic finish_test(input string name);
    // Let the checker count the last response first
    @(negedge clk);
    tests_run++;
    $display("Test %0d %-12s %0d transactions, %0d failures", tests_run, name,
             check_txns - txns_mark, check_errors - errors_mark);
    txns_mark   = check_txns;
    errors_mark = check_errors;
  endtask

  initial begin
    void'($urandom(Seed));
    rst_n        = 1'b0;
    bootmode     = BootJtag;
    fetch_enable = 1'b0;
    req_valid    = '0;
    rsp_ready    = '0;
    addr         = '0;
    we           = '0;
    be           = '0;
    wdata        = '0;
    bp_mode      = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;
    repeat (4) @(negedge clk);

    // First tie after reset goes to host
    fork
      run_txn(0, PeriphBase + RegBootAddrOff, 1'b0, 4'hF, '0);
      run_txn(1, PeriphBase + RegFetchEnOff, 1'b0, 4'hF, '0);
    join
    run_txn(0, PeriphBase + RegBootModeOff, 1'b0, 4'hF, '0);
    finish_test("reset_state");

    // Fill both banks so that every later read is defined
    fork
      for (int i = 0; i < BankNumWords; i++) run_txn(0, Bank0Base + 4 * i, 1'b1, 4'hF, $urandom);
      for (int i = 0; i < BankNumWords; i++) run_txn(1, Bank1Base + 4 * i, 1'b1, 4'hF, $urandom);
    join
    random_traffic(0, RandomTxns);
    random_traffic(1, RandomTxns);
    finish_test("memory");

    run_txn(0, PeriphBase + RegFetchEnOff, 1'b1, 4'hF, '0);
    repeat (3) @(negedge clk);
    fetch_enable = 1'b1;
    repeat (3) @(negedge clk);
    fetch_enable = 1'b0;
    run_txn(1, PeriphBase + RegBootAddrOff, 1'b1, 4'h1, $urandom & 32'hFFFF_FFFC);
    run_txn(0, PeriphBase + RegBootAddrOff, 1'b0, 4'hF, '0);
    run_txn(1, PeriphBase + 32'hC, 1'b0, 4'hF, '0);
    run_txn(0, PeriphBase + 32'hC, 1'b1, 4'hF, $urandom);
    run_txn(0, PeriphBase + RegFetchEnOff, 1'b1, 4'hF, 32'h1);
    run_txn(1, PeriphBase + RegFetchEnOff, 1'b0, 4'hF, '0);
    run_txn(0, PeriphBase + RegBootModeOff, 1'b1, 4'hF, 32'(BootPreloaded));
    run_txn(1, PeriphBase + RegBootModeOff, 1'b0, 4'hF, '0);
    finish_test("soc_ctrl");

    repeat (UnmappedIters) begin
      run_txn(0, random_unmapped_addr(), 1'b0, 4'hF, '0);
      run_txn(1, random_unmapped_addr(), 1'b1, 4'hF, $urandom);
      run_txn(0, random_bank_addr(), 1'b0, 4'hF, '0);
    end
    finish_test("unmapped");

    fork
      random_traffic(0, RandomTxns);
      random_traffic(1, RandomTxns);
    join
    finish_test("arbitration");

    bp_mode = 1'b1;
    fork
      random_traffic(0, RandomTxns);
      random_traffic(1, RandomTxns);
    join
    bp_mode = 1'b0;
    finish_test("backpressure");

    repeat (4) @(negedge clk);
    if (check_txns != issued) begin
      $display("Checker saw %0d responses but %0d transactions were issued",
               check_txns, issued);
    end
    $display("Summary %0d tests, %0d transactions, %0d failures", tests_run, check_txns,
             check_errors);
    if (check_errors == 0 && check_txns == issued) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: sim.f
src/island_pkg.sv
src/island_bus_if.sv
src/bus_arbiter.sv
src/addr_router.sv
src/sram_bank.sv
src/soc_ctrl_regs.sv
src/island_top.sv
dv/island_checker.sv
dv/tb_top.sv

// File: Makefile
# Verilator build and run for the safety-island interconnect

SIM      ?= verilator
TOP      := tb_top
FILELIST := sim.f
BUILD    := obj_dir
LOG      := sim.log
VFLAGS   := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build tb_top with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(VFLAGS) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qx "STATUS: PASS" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
